// ==== design/kernel_consts.svh ====
`ifndef KERNEL_CONSTS_SVH
`define KERNEL_CONSTS_SVH

// data word width.
`define KERNEL_WIDTH 32

// words per operand and result memory.
`define KERNEL_SIZE 16

// index width, log2 of the memory size.
`define KERNEL_IDX 4

// length field holds 0 up to KERNEL_SIZE.
`define KERNEL_LEN_W 5

`endif

// ==== design/datapath_pkg.sv ====
`default_nettype none

`include "kernel_consts.svh"

package datapath_pkg;

  // one opcode per library primitive.
  typedef enum logic [3:0] {
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_NOT,  // right is ignored.
    OP_LT,
    OP_GT,
    OP_EQ,
    OP_NEQ,
    OP_GE,
    OP_LE,
    OP_LSH,
    OP_RSH
  } alu_op_e;

  typedef struct packed {
    alu_op_e                  op;
    logic [`KERNEL_WIDTH-1:0] left;
    logic [`KERNEL_WIDTH-1:0] right;
  } alu_req_t;

  // write side of a d1 memory.
  typedef struct packed {
    logic                     write_en;
    logic [`KERNEL_IDX-1:0]   addr;
    logic [`KERNEL_WIDTH-1:0] write_data;
  } mem_wr_t;

endpackage

`default_nettype wire

// ==== design/control_pkg.sv ====
`default_nettype none

`include "kernel_consts.svh"

package control_pkg;
  import datapath_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,  // result write strobe.
    S_WAIT,  // wait for C done.
    S_DONE
  } ctrl_state_e;

  // latched at the go edge.
  typedef struct packed {
    alu_op_e                  op;
    logic [`KERNEL_LEN_W-1:0] len;
  } kernel_cmd_t;

  // host operand write, sel 0 is A and 1 is B.
  typedef struct packed {
    logic                     en;
    logic                     sel;
    logic [`KERNEL_IDX-1:0]   addr;
    logic [`KERNEL_WIDTH-1:0] data;
  } load_t;

endpackage

`default_nettype wire

// ==== design/std_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kernel_consts.svh"

module std_alu
  import datapath_pkg::*;
(
  input  wire alu_req_t             req,
  output logic [`KERNEL_WIDTH-1:0] result
);

  localparam int SHAMT_W = $clog2(`KERNEL_WIDTH);

  logic [SHAMT_W-1:0]       shamt;
  logic                     cmp_bit;
  logic [`KERNEL_WIDTH-1:0] cmp_word;

  // slice, amounts of 32 and up wrap to the low five bits.
  assign shamt = req.right[SHAMT_W-1:0];

  // unsigned compares, one bit each.
  always_comb begin
    case (req.op)
      OP_LT:   cmp_bit = req.left < req.right;
      OP_GT:   cmp_bit = req.left > req.right;
      OP_EQ:   cmp_bit = req.left == req.right;
      OP_NEQ:  cmp_bit = req.left != req.right;
      OP_GE:   cmp_bit = req.left >= req.right;
      OP_LE:   cmp_bit = req.left <= req.right;
      default: cmp_bit = 1'b0;
    endcase
  end

  // pad to a full word.
  assign cmp_word = {{(`KERNEL_WIDTH-1){1'b0}}, cmp_bit};

  always_comb begin
    case (req.op)
      OP_SUB: result = req.left - req.right;
      OP_AND: result = req.left & req.right;
      OP_OR:  result = req.left | req.right;
      OP_XOR: result = req.left ^ req.right;
      OP_NOT: result = ~req.left;
      OP_LT,
      OP_GT,
      OP_EQ,
      OP_NEQ,
      OP_GE,
      OP_LE: begin
        result = cmp_word;
      end
      OP_LSH: result = req.left << shamt;
      OP_RSH: result = req.left >> shamt;  // logical.
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/std_mem_d1.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kernel_consts.svh"

module std_mem_d1
  import datapath_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire mem_wr_t                wr,
  input  wire logic [`KERNEL_IDX-1:0] addr0,
  output logic [`KERNEL_WIDTH-1:0]    read_data,
  output logic                        done
);

  logic [`KERNEL_WIDTH-1:0] mem [`KERNEL_SIZE];

  // read port, no latency.
  assign read_data = mem[addr0];

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= wr.write_en;  // one cycle after the write.
    end
  end

  always_ff @(posedge clk) begin
    if (!reset && wr.write_en) begin
      mem[wr.addr] <= wr.write_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/vec_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kernel_consts.svh"

module vec_ctrl
  import datapath_pkg::*;
  import control_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     go,
  input  wire kernel_cmd_t              cmd,
  input  wire logic [`KERNEL_WIDTH-1:0] a_data,
  input  wire logic [`KERNEL_WIDTH-1:0] b_data,
  input  wire logic                     c_done,
  output logic [`KERNEL_IDX-1:0]        idx,
  output alu_req_t                      alu_req,
  output logic [`KERNEL_WIDTH-1:0]      alu_result,
  output logic                          c_wr_en,
  output logic                          busy,
  output logic                          done
);

  localparam int LEN_W = `KERNEL_LEN_W;

  ctrl_state_e      state;
  ctrl_state_e      state_next;
  kernel_cmd_t      cmd_q;
  logic [LEN_W-1:0] count_next;
  logic             start;
  logic             last;

  // go only counts while idle.
  assign start = (state == S_IDLE) && go;

  // elements done once the current one lands.
  assign count_next = LEN_W'(idx) + LEN_W'(1);
  assign last       = (count_next == cmd_q.len);

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (go) begin
          // empty run skips straight to done.
          state_next = (cmd.len == '0) ? S_DONE : S_EXEC;
        end
      end
      S_EXEC: begin
        state_next = S_WAIT;
      end
      S_WAIT: begin
        if (c_done) begin
          state_next = last ? S_DONE : S_EXEC;
        end
      end
      S_DONE: begin
        state_next = S_IDLE;
      end
      default: begin
        state_next = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      idx   <= '0;
    end else begin
      state <= state_next;
      if (start) begin
        idx <= '0;
      end else if ((state == S_WAIT) && c_done && !last) begin
        idx <= count_next[`KERNEL_IDX-1:0];
      end
    end
  end

  // opcode and length held for the whole run.
  always_ff @(posedge clk) begin
    if (start) begin
      cmd_q <= cmd;
    end
  end

  // A and B are both read at idx.
  assign alu_req = '{op: cmd_q.op, left: a_data, right: b_data};

  std_alu alu (
    .req    (alu_req),
    .result (alu_result)
  );

  assign c_wr_en = (state == S_EXEC);  // one strobe per element.
  assign busy    = (state == S_EXEC) || (state == S_WAIT);
  assign done    = (state == S_DONE);

endmodule

`default_nettype wire

// ==== design/vec_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kernel_consts.svh"

module vec_kernel
  import datapath_pkg::*;
  import control_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   go,
  input  wire kernel_cmd_t            cmd,
  input  wire load_t                  load,
  input  wire logic [`KERNEL_IDX-1:0] rd_addr,
  output logic [`KERNEL_WIDTH-1:0]    rd_data,
  output logic                        busy,
  output logic                        done
);

  mem_wr_t                  a_wr;
  mem_wr_t                  b_wr;
  mem_wr_t                  c_wr;
  logic                     load_ok;
  logic                     c_wr_en;
  logic                     c_done;
  logic [`KERNEL_IDX-1:0]   idx;
  logic [`KERNEL_IDX-1:0]   c_addr;
  logic [`KERNEL_WIDTH-1:0] a_data;
  logic [`KERNEL_WIDTH-1:0] b_data;
  logic [`KERNEL_WIDTH-1:0] alu_result;

  // loads during a run are dropped.
  assign load_ok = load.en && !busy;

  assign a_wr = '{write_en: load_ok && !load.sel, addr: load.addr, write_data: load.data};
  assign b_wr = '{write_en: load_ok && load.sel, addr: load.addr, write_data: load.data};
  assign c_wr = '{write_en: c_wr_en, addr: idx, write_data: alu_result};

  // host owns the C read address when idle.
  assign c_addr = busy ? idx : rd_addr;

  std_mem_d1 mem_a (
    .clk       (clk),
    .reset     (reset),
    .wr        (a_wr),
    .addr0     (idx),
    .read_data (a_data),
    .done      ()
  );

  std_mem_d1 mem_b (
    .clk       (clk),
    .reset     (reset),
    .wr        (b_wr),
    .addr0     (idx),
    .read_data (b_data),
    .done      ()
  );

  std_mem_d1 mem_c (
    .clk       (clk),
    .reset     (reset),
    .wr        (c_wr),
    .addr0     (c_addr),
    .read_data (rd_data),
    .done      (c_done)
  );

  vec_ctrl ctrl (
    .clk        (clk),
    .reset      (reset),
    .go         (go),
    .cmd        (cmd),
    .a_data     (a_data),
    .b_data     (b_data),
    .c_done     (c_done),
    .idx        (idx),
    .alu_req    (),
    .alu_result (alu_result),
    .c_wr_en    (c_wr_en),
    .busy       (busy),
    .done       (done)
  );

endmodule

`default_nettype wire

// ==== verification/vec_kernel_tasks.svh ====
`ifndef VEC_KERNEL_TASKS_SVH
`define VEC_KERNEL_TASKS_SVH

task automatic check_word(input string name, input logic [`KERNEL_WIDTH-1:0] got,
                          input logic [`KERNEL_WIDTH-1:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("ERR %s got %h expected %h", name, got, exp);
  end
endtask

// one host write, entered and left on a falling edge.
task automatic load_word(input logic is_b, input int addr, input logic [`KERNEL_WIDTH-1:0] data);
  load = '{en: 1'b1, sel: is_b, addr: IDX_W'(addr), data: data};
  @(negedge clk);
  load.en = 1'b0;
endtask

// counts falling edges from go up to the one that shows done.
task automatic wait_done(input logic hold_go, output int cycles);
  cycles = 0;
  while (!done && cycles < DONE_LIMIT) begin
    @(negedge clk);
    cycles++;
    if (!hold_go) begin
      go = 1'b0;
    end
  end
  if (!done) begin
    errors++;
    $display("done never arrived, gave up after %0d cycles", DONE_LIMIT);
  end else begin
    check_flag("busy", busy, 1'b0);
  end
  @(negedge clk);
  check_flag("done", done, 1'b0);  // single cycle pulse.
endtask

task automatic run_kernel(input alu_op_e op, input int len, output int cycles);
  cmd = '{op: op, len: LEN_W'(len)};
  go  = 1'b1;
  wait_done(1'b0, cycles);
endtask

// reads all of C back through rd_addr.
task automatic verify_c();
  for (int i = 0; i < `KERNEL_SIZE; i++) begin
    rd_addr = IDX_W'(i);
    #1;
    check_word($sformatf("C[%0d]", i), rd_data, c_ref[i]);
    @(negedge clk);
  end
endtask

task automatic after_reset_flags();
  check_flag("done", done, 1'b0);
  check_flag("busy", busy, 1'b0);
endtask

task automatic load_operands();
  for (int i = 0; i < `KERNEL_SIZE; i++) begin
    a_ref[i] = $urandom();
    b_ref[i] = $urandom();
  end
  b_ref[0] = a_ref[0];  // equal operands.
  b_ref[5] = a_ref[5];
  b_ref[1] = 32'd31;
  b_ref[2] = 32'hffff_ffff;  // amount 31 from a large value.
  b_ref[3] = 32'd37;
  b_ref[4] = 32'd32;
  a_ref[6] = 32'h8000_0001;
  for (int i = 0; i < `KERNEL_SIZE; i++) begin
    load_word(1'b0, i, a_ref[i]);
    load_word(1'b1, i, b_ref[i]);
  end
endtask

task automatic every_opcode();
  alu_op_e op;
  int      cycles;
  op = op.first();
  repeat (op.num()) begin
    run_kernel(op, `KERNEL_SIZE, cycles);
    check_word($sformatf("done latency %s", op.name()), cycles, 2 * `KERNEL_SIZE + 1);
    apply_model(op, `KERNEL_SIZE);
    verify_c();
    op = op.next();
  end
endtask

task automatic done_latency();
  int lens [3] = '{1, 5, `KERNEL_SIZE};
  int cycles;
  foreach (lens[k]) begin
    run_kernel(OP_XOR, lens[k], cycles);
    check_word($sformatf("done latency len %0d", lens[k]), cycles, 2 * lens[k] + 1);
    apply_model(OP_XOR, lens[k]);
  end
  // empty run, C keeps the xor words.
  run_kernel(OP_NOT, 0, cycles);
  check_word("done latency len 0", cycles, 1);
  verify_c();
endtask

task automatic partial_length();
  int cycles;
  run_kernel(OP_NOT, `KERNEL_SIZE, cycles);
  apply_model(OP_NOT, `KERNEL_SIZE);
  run_kernel(OP_AND, 6, cycles);
  apply_model(OP_AND, 6);
  verify_c();
endtask

task automatic load_while_busy();
  int cycles;
  cmd = '{op: OP_SUB, len: LEN_W'(`KERNEL_SIZE)};
  go  = 1'b1;
  @(negedge clk);
  go = 1'b0;
  check_flag("busy", busy, 1'b1);
  for (int i = 0; i < 4; i++) begin
    load_word(1'b0, i, ~a_ref[i]);
    load_word(1'b1, i, b_ref[i] + 32'd1);
  end
  check_flag("busy", busy, 1'b1);
  wait_done(1'b0, cycles);
  run_kernel(OP_OR, `KERNEL_SIZE, cycles);
  apply_model(OP_OR, `KERNEL_SIZE);  // operands as first loaded.
  verify_c();
endtask

task automatic go_held_high();
  int cycles;
  cmd = '{op: OP_RSH, len: LEN_W'(`KERNEL_SIZE)};
  go  = 1'b1;
  wait_done(1'b1, cycles);
  check_word("first done latency", cycles, 2 * `KERNEL_SIZE + 1);
  // next edge starts again from idle.
  cmd.op = OP_LSH;
  @(negedge clk);
  check_flag("busy", busy, 1'b1);
  // running command stays the latched one.
  cmd = '{op: OP_SUB, len: LEN_W'(3)};
  wait_done(1'b0, cycles);
  check_word("second done latency", cycles, 2 * `KERNEL_SIZE);  // first exec cycle gone.
  check_flag("busy", busy, 1'b0);
  apply_model(OP_LSH, `KERNEL_SIZE);
  verify_c();
endtask

`endif

// ==== verification/vec_kernel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "kernel_consts.svh"

module vec_kernel_tb
  import datapath_pkg::*;
  import control_pkg::*;
();

  localparam int IDX_W           = `KERNEL_IDX;
  localparam int LEN_W           = `KERNEL_LEN_W;
  localparam int NUM_RUNS        = 23;
  localparam int RUN_CYCLES      = 2 * `KERNEL_SIZE + 10;
  localparam int DONE_LIMIT      = RUN_CYCLES;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_CYCLES + 200;

  logic                     clk;
  logic                     reset;
  logic                     go;
  kernel_cmd_t              cmd;
  load_t                    load;
  logic [`KERNEL_IDX-1:0]   rd_addr;
  logic [`KERNEL_WIDTH-1:0] rd_data;
  logic                     busy;
  logic                     done;

  // host side copies of the operands and the expected C.
  logic [`KERNEL_WIDTH-1:0] a_ref [`KERNEL_SIZE];
  logic [`KERNEL_WIDTH-1:0] b_ref [`KERNEL_SIZE];
  logic [`KERNEL_WIDTH-1:0] c_ref [`KERNEL_SIZE];

  int checks;
  int errors;

  vec_kernel DUT (
    .clk     (clk),
    .reset   (reset),
    .go      (go),
    .cmd     (cmd),
    .load    (load),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .busy    (busy),
    .done    (done)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period.

  // expected result of one element.
  function automatic logic [`KERNEL_WIDTH-1:0] alu_model(input alu_op_e op,
      input logic [`KERNEL_WIDTH-1:0] l, input logic [`KERNEL_WIDTH-1:0] r);
    int amount;
    amount = int'(r % `KERNEL_WIDTH);  // low five bits of right.
    case (op)
      OP_SUB: return l - r;
      OP_AND: return l & r;
      OP_OR:  return l | r;
      OP_XOR: return l ^ r;
      OP_NOT: return ~l;
      OP_LT:  return (l < r) ? 1 : 0;
      OP_GT:  return (l > r) ? 1 : 0;
      OP_EQ:  return (l == r) ? 1 : 0;
      OP_NEQ: return (l != r) ? 1 : 0;
      OP_GE:  return (l >= r) ? 1 : 0;
      OP_LE:  return (l <= r) ? 1 : 0;
      OP_LSH: return l << amount;
      OP_RSH: return l >> amount;
      default: return '0;
    endcase
  endfunction

  function automatic void apply_model(input alu_op_e op, input int len);
    for (int i = 0; i < len; i++) begin
      c_ref[i] = alu_model(op, a_ref[i], b_ref[i]);
    end
  endfunction

  `include "vec_kernel_tasks.svh"

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog timeout after %0d cycles, tests did not complete, errors %0d",
             WATCHDOG_CYCLES, errors);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(12));
    checks  = 0;
    errors  = 0;
    reset   = 1'b1;
    go      = 1'b0;
    cmd     = '0;
    load    = '0;
    rd_addr = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    after_reset_flags();
    load_operands();
    every_opcode();
    done_latency();
    partial_length();
    load_while_busy();
    go_held_high();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vec_kernel.f ====
+incdir+design
+incdir+verification
design/datapath_pkg.sv
design/control_pkg.sv
design/std_alu.sv
design/std_mem_d1.sv
design/vec_ctrl.sv
design/vec_kernel.sv
verification/vec_kernel_tb.sv
